// ==== Makefile ====
sim:
	verilator --binary --assert --timing -Wno-fatal --top-module tb_router -f files.f -o tb_router
	./obj_dir/tb_router +verilator+error+limit+1000 | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== files.f ====
src/router_pkg.sv
src/flit_fifo.sv
src/input_port.sv
src/route_comp.sv
src/switch_alloc.sv
src/output_port.sv
src/router.sv
tb/router_assertions.sv
tb/router_checker.sv
tb/tb_router.sv

// ==== src/flit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module flit_fifo
    import router_pkg::*;
#(
    parameter int depth = QUEUE_DEPTH
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire link_t in,
    output flit_t      out,
    output logic       empty,
    input  wire logic  pop,
    output credit_t    used
);

    localparam int AW = (depth > 1) ? $clog2(depth) : 1;

    flit_t mem [depth];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic do_write;
    logic do_read;

    function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
        return (ptr == AW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (used == '0);
    assign do_read = pop && !empty;
    // full queue drops the write unless a pop frees a slot
    assign do_write = in.valid && ((used < credit_t'(depth)) || do_read);
    assign out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in.flit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= bump(rd_ptr);
            end
            used <= used + credit_t'(do_write) - credit_t'(do_read);
        end
    end

endmodule

`default_nettype wire

// ==== src/input_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_port
    import router_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire link_t link_in,
    output link_t      head,
    input  wire logic  pop,
    output credit_t    downstream_credits,
    output credit_t    upstream_credits
);

    logic is_credit;
    link_t data_in;
    flit_t queue_out;
    logic queue_empty;
    credit_t queue_used;

    assign is_credit = (link_in.flit.kind == CREDIT);

    // credit flits never reach the queue
    assign data_in = '{valid: link_in.valid && !is_credit, flit: link_in.flit};

    always_ff @(posedge clk) begin
        if (rst) begin
            downstream_credits <= credit_t'(QUEUE_DEPTH - 1);
        end else if (link_in.valid && is_credit) begin
            downstream_credits <= link_in.flit.payload[$bits(credit_t)-1:0];
        end
    end

    flit_fifo #(
        .depth(QUEUE_DEPTH)
    ) u_queue (
        .clk(clk),
        .rst(rst),
        .in(data_in),
        .out(queue_out),
        .empty(queue_empty),
        .pop(pop),
        .used(queue_used)
    );

    assign head = '{valid: !queue_empty, flit: queue_out};

    // free space as seen by the upstream sender
    assign upstream_credits = credit_t'(QUEUE_DEPTH - 1) - queue_used;

endmodule

`default_nettype wire

// ==== src/output_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_port
    import router_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire link_t   sw_in,
    output logic         sw_ready,
    input  wire link_t   inject,
    output logic         inject_avail,
    input  wire logic    credit_slot,
    input  wire credit_t downstream_credits,
    input  wire credit_t upstream_credits,
    output link_t        link_out
);

    logic down_avail;
    logic inj_lock;
    logic thru_open;
    logic thru_take;
    logic inj_take;
    flit_t credit_flit;

    assign down_avail = (downstream_credits >= credit_t'(CREDIT_THRESHOLD));

    assign sw_ready = down_avail && !credit_slot && !inj_lock;

    // injection waits for a gap between through packets
    assign inject_avail = down_avail && !credit_slot &&
                          (inj_lock || (!sw_in.valid && !thru_open));

    assign thru_take = sw_in.valid && sw_ready;
    assign inj_take = inject.valid && inject_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            inj_lock <= 1'b0;
            thru_open <= 1'b0;
        end else begin
            if (inj_take && (inject.flit.kind == HEAD) && !sw_in.valid) begin
                inj_lock <= 1'b1;
            end else if (inj_take && (inject.flit.kind == TAIL)) begin
                inj_lock <= 1'b0;
            end
            if (thru_take) begin
                thru_open <= (sw_in.flit.kind != TAIL);
            end
        end
    end

    // credit slot first, then through traffic, then injection
    always_comb begin
        credit_flit = '{kind: CREDIT, payload: '0};
        credit_flit.payload[$bits(credit_t)-1:0] = upstream_credits;
        link_out = '{valid: 1'b0, flit: sw_in.flit};
        if (credit_slot) begin
            link_out = '{valid: 1'b1, flit: credit_flit};
        end else if (thru_take) begin
            link_out = sw_in;
        end else if (inj_take) begin
            link_out = inject;
        end
    end

endmodule

`default_nettype wire

// ==== src/route_comp.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_comp
    import router_pkg::*;
#(
    parameter int cur_x = 0,
    parameter int cur_y = 0,
    parameter int cur_z = 0
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire link_t head,
    output logic       pop,
    output link_t      req,
    output route_t     route,
    input  wire logic  grant,
    output link_t      eject
);

    logic [COORD_W-1:0] dst_x;
    logic [COORD_W-1:0] dst_y;
    logic [COORD_W-1:0] dst_z;
    logic in_pkt;
    logic starts_pkt;
    route_t new_route;
    route_t hold_route;
    route_t head_route;
    logic req_valid;
    flit_t req_flit;
    route_t req_route;
    logic eject_valid;
    flit_t eject_flit;

    assign dst_x = head.flit.payload[DEST_X_LSB +: COORD_W];
    assign dst_y = head.flit.payload[DEST_Y_LSB +: COORD_W];
    assign dst_z = head.flit.payload[DEST_Z_LSB +: COORD_W];

    // lone tail outside a packet starts and ends it
    assign starts_pkt = (head.flit.kind == HEAD) || ((head.flit.kind == TAIL) && !in_pkt);

    // x first, then y, then z
    always_comb begin
        if (dst_x > COORD_W'(cur_x)) begin
            new_route = '{eject: 1'b0, port: XPOS};
        end else if (dst_x < COORD_W'(cur_x)) begin
            new_route = '{eject: 1'b0, port: XNEG};
        end else if (dst_y > COORD_W'(cur_y)) begin
            new_route = '{eject: 1'b0, port: YPOS};
        end else if (dst_y < COORD_W'(cur_y)) begin
            new_route = '{eject: 1'b0, port: YNEG};
        end else if (dst_z > COORD_W'(cur_z)) begin
            new_route = '{eject: 1'b0, port: ZPOS};
        end else if (dst_z < COORD_W'(cur_z)) begin
            new_route = '{eject: 1'b0, port: ZNEG};
        end else begin
            new_route = '{eject: 1'b1, port: XPOS};
        end
    end

    assign head_route = starts_pkt ? new_route : hold_route;

    // ejects never stall, through flits need a free holding register
    assign pop = head.valid && (head_route.eject || !req_valid || grant);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
            hold_route <= '0;
            req_valid <= 1'b0;
            eject_valid <= 1'b0;
        end else begin
            eject_valid <= pop && head_route.eject;
            if (pop) begin
                in_pkt <= (head.flit.kind != TAIL);
                hold_route <= head_route;
            end
            if (pop && !head_route.eject) begin
                req_valid <= 1'b1;
            end else if (grant) begin
                req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !head_route.eject) begin
            req_flit <= head.flit;
            req_route <= head_route;
        end
        if (pop && head_route.eject) begin
            eject_flit <= head.flit;
        end
    end

    assign req = '{valid: req_valid, flit: req_flit};
    assign route = req_route;
    assign eject = '{valid: eject_valid, flit: eject_flit};

endmodule

`default_nettype wire

// ==== src/router.sv ====
`timescale 1ns/1ps
`default_nettype none

module router
    import router_pkg::*;
#(
    parameter int cur_x = 0,
    parameter int cur_y = 0,
    parameter int cur_z = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire link_t [PORT_NUM-1:0] link_in,
    output link_t      [PORT_NUM-1:0] link_out,
    input  wire link_t [PORT_NUM-1:0] inject,
    output link_t      [PORT_NUM-1:0] eject,
    output logic       [PORT_NUM-1:0] inject_avail
);

    localparam int SLOT_W = $clog2(CREDIT_PERIOD);

    logic [SLOT_W-1:0] slot_cnt;
    logic credit_slot;
    link_t [PORT_NUM-1:0] q_head;
    logic [PORT_NUM-1:0] q_pop;
    link_t [PORT_NUM-1:0] sw_req;
    route_t [PORT_NUM-1:0] sw_route;
    logic [PORT_NUM-1:0] sw_grant;
    logic [PORT_NUM-1:0] sw_ready;
    link_t [PORT_NUM-1:0] sw_out;
    credit_t [PORT_NUM-1:0] down_credits;
    credit_t [PORT_NUM-1:0] up_credits;

    // shared credit-back period
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (slot_cnt == SLOT_W'(CREDIT_PERIOD - 1)) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    assign credit_slot = (slot_cnt == SLOT_W'(CREDIT_PERIOD - 1));

    for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
        input_port u_in (
            .clk(clk),
            .rst(rst),
            .link_in(link_in[p]),
            .head(q_head[p]),
            .pop(q_pop[p]),
            .downstream_credits(down_credits[p]),
            .upstream_credits(up_credits[p])
        );

        route_comp #(
            .cur_x(cur_x),
            .cur_y(cur_y),
            .cur_z(cur_z)
        ) u_rc (
            .clk(clk),
            .rst(rst),
            .head(q_head[p]),
            .pop(q_pop[p]),
            .req(sw_req[p]),
            .route(sw_route[p]),
            .grant(sw_grant[p]),
            .eject(eject[p])
        );

        // same index on both ends of the link
        output_port u_out (
            .clk(clk),
            .rst(rst),
            .sw_in(sw_out[p]),
            .sw_ready(sw_ready[p]),
            .inject(inject[p]),
            .inject_avail(inject_avail[p]),
            .credit_slot(credit_slot),
            .downstream_credits(down_credits[p]),
            .upstream_credits(up_credits[p]),
            .link_out(link_out[p])
        );
    end

    switch_alloc u_sw (
        .clk(clk),
        .rst(rst),
        .req(sw_req),
        .route(sw_route),
        .grant(sw_grant),
        .sw_ready(sw_ready),
        .out(sw_out)
    );

endmodule

`default_nettype wire

// ==== src/router_pkg.sv ====
`default_nettype none

package router_pkg;

    localparam int PORT_NUM = 6;
    localparam int FLIT_W = 32;
    localparam int COORD_W = 3;
    localparam int QUEUE_DEPTH = 16;
    localparam int CREDIT_PERIOD = 20;
    localparam int CREDIT_THRESHOLD = 10;

    localparam int PAYLOAD_W = FLIT_W - 2;
    // destination fields sit at the top of a head payload
    localparam int DEST_X_LSB = PAYLOAD_W - COORD_W;
    localparam int DEST_Y_LSB = DEST_X_LSB - COORD_W;
    localparam int DEST_Z_LSB = DEST_Y_LSB - COORD_W;

    // a one-flit packet is a lone TAIL that carries the head fields
    typedef enum logic [1:0] {
        HEAD   = 2'd0,
        BODY   = 2'd1,
        TAIL   = 2'd2,
        CREDIT = 2'd3
    } flit_kind_t;

    typedef struct packed {
        flit_kind_t kind;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    typedef struct packed {
        logic valid;
        flit_t flit;
    } link_t;

    typedef logic [2:0] port_id_t;

    localparam port_id_t XPOS = 3'd0;
    localparam port_id_t YPOS = 3'd1;
    localparam port_id_t ZPOS = 3'd2;
    localparam port_id_t XNEG = 3'd3;
    localparam port_id_t YNEG = 3'd4;
    localparam port_id_t ZNEG = 3'd5;

    typedef struct packed {
        logic eject;
        port_id_t port;
    } route_t;

    // credit value rides in the low payload bits
    typedef logic [4:0] credit_t;

endpackage

`default_nettype wire

// ==== src/switch_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_alloc
    import router_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire link_t  [PORT_NUM-1:0] req,
    input  wire route_t [PORT_NUM-1:0] route,
    output logic        [PORT_NUM-1:0] grant,
    input  wire logic   [PORT_NUM-1:0] sw_ready,
    output link_t       [PORT_NUM-1:0] out
);

    logic [PORT_NUM-1:0] locked;
    port_id_t [PORT_NUM-1:0] lock_id;
    port_id_t [PORT_NUM-1:0] rr_ptr;
    port_id_t [PORT_NUM-1:0] sel;
    logic [PORT_NUM-1:0] sel_valid;
    logic [PORT_NUM-1:0] moved;

    function automatic logic wants(input link_t r, input route_t rt, input int o);
        return r.valid && !rt.eject && (rt.port == port_id_t'(o));
    endfunction

    function automatic port_id_t next_port(input port_id_t p);
        return (p == port_id_t'(PORT_NUM - 1)) ? '0 : p + 1'b1;
    endfunction

    // a locked output keeps its owner until the tail
    always_comb begin
        port_id_t idx;
        logic found;
        for (int o = 0; o < PORT_NUM; o++) begin
            idx = rr_ptr[o];
            found = 1'b0;
            sel[o] = lock_id[o];
            if (locked[o]) begin
                found = wants(req[lock_id[o]], route[lock_id[o]], o);
            end else begin
                // round robin from the pointer
                for (int k = 0; k < PORT_NUM; k++) begin
                    if (!found && wants(req[idx], route[idx], o)) begin
                        found = 1'b1;
                        sel[o] = idx;
                    end
                    idx = next_port(idx);
                end
            end
            sel_valid[o] = found;
        end
    end

    // crossbar and grant back to the inputs
    always_comb begin
        grant = '0;
        for (int o = 0; o < PORT_NUM; o++) begin
            out[o] = '{valid: sel_valid[o], flit: req[sel[o]].flit};
            moved[o] = sel_valid[o] && sw_ready[o];
            if (moved[o]) begin
                grant[sel[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= '0;
            lock_id <= '0;
            rr_ptr <= '0;
        end else begin
            for (int o = 0; o < PORT_NUM; o++) begin
                if (moved[o]) begin
                    if (req[sel[o]].flit.kind == TAIL) begin
                        locked[o] <= 1'b0;
                        rr_ptr[o] <= next_port(sel[o]);
                    end else begin
                        locked[o] <= 1'b1;
                        lock_id[o] <= sel[o];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/router_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_assertions
    import router_pkg::*;
(
    input wire logic                   clk,
    input wire logic                   rst,
    input wire logic  [PORT_NUM-1:0]   inject_avail,
    input wire link_t [PORT_NUM-1:0]   link_out,
    input wire logic                   credit_slot,
    input wire credit_t [PORT_NUM-1:0] down_credits
);

    for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
        // slot cycles belong to the credit flit
        avail_in_slot: assert property (@(posedge clk) disable iff (rst)
            credit_slot |-> !inject_avail[p])
            else $error("inject_avail high during a credit slot on port %0d", p);

        gated_send: assert property (@(posedge clk) disable iff (rst)
            (link_out[p].valid && (link_out[p].flit.kind != CREDIT))
                |-> (down_credits[p] >= credit_t'(CREDIT_THRESHOLD)))
            else $error("data flit sent on port %0d with low downstream credits", p);
    end

endmodule

`default_nettype wire

// ==== tb/router_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_checker
    import router_pkg::*;
#(
    parameter int cur_x = 0,
    parameter int cur_y = 0,
    parameter int cur_z = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire link_t [PORT_NUM-1:0] link_in,
    input  wire link_t [PORT_NUM-1:0] link_out,
    input  wire link_t [PORT_NUM-1:0] inject,
    input  wire link_t [PORT_NUM-1:0] eject,
    input  wire logic  [PORT_NUM-1:0] inject_avail,
    input  wire logic                 done,
    output int                        error_count,
    output logic                      reported
);

    // source index PORT_NUM stands for local injection
    flit_t path_q [PORT_NUM*PORT_NUM][$];
    flit_t inj_q [PORT_NUM][$];
    flit_t eject_q [PORT_NUM][$];
    int pending [PORT_NUM];
    int owner [PORT_NUM];
    int in_route [PORT_NUM];
    logic in_pkt [PORT_NUM];
    credit_t model_down [PORT_NUM];
    int slot_cnt;
    int outstanding;
    int check_count;

    // x first, then y, then z; PORT_NUM means eject
    function automatic int dimension_order_exit(input logic [PAYLOAD_W-1:0] pl);
        int x;
        int y;
        int z;
        x = int'(pl[DEST_X_LSB +: COORD_W]);
        y = int'(pl[DEST_Y_LSB +: COORD_W]);
        z = int'(pl[DEST_Z_LSB +: COORD_W]);
        if (x > cur_x) return 0;
        if (x < cur_x) return 3;
        if (y > cur_y) return 1;
        if (y < cur_y) return 4;
        if (z > cur_z) return 2;
        if (z < cur_z) return 5;
        return PORT_NUM;
    endfunction

    function automatic logic front_is(input int s, input int o, input flit_t f);
        if (s == PORT_NUM) begin
            return (inj_q[o].size() > 0) && (inj_q[o][0] == f);
        end
        return (path_q[s*PORT_NUM+o].size() > 0) && (path_q[s*PORT_NUM+o][0] == f);
    endfunction

    // an open packet only continues from its own source
    function automatic int find_source(input int o, input flit_t f);
        int found;
        found = -1;
        if (owner[o] >= 0) begin
            return front_is(owner[o], o, f) ? owner[o] : -1;
        end
        for (int s = 0; s <= PORT_NUM; s++) begin
            if (found < 0 && front_is(s, o, f)) begin
                found = s;
            end
        end
        return found;
    endfunction

    task automatic report_err(input string msg);
        error_count++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic check_output(input int o, input logic slot);
        flit_t f;
        int src;
        f = link_out[o].flit;
        if (slot) begin
            check_count++;
            if (!link_out[o].valid || f.kind != CREDIT) begin
                report_err($sformatf("output %0d has no credit flit in the slot", o));
            end else if ((f.payload >> $bits(credit_t)) != '0 ||
                         f.payload[$bits(credit_t)-1:0] > credit_t'(QUEUE_DEPTH - 1)) begin
                report_err($sformatf("output %0d credit payload %h out of range", o, f.payload));
            end else if (pending[o] == 0 &&
                         f.payload[$bits(credit_t)-1:0] != credit_t'(QUEUE_DEPTH - 1)) begin
                report_err($sformatf("output %0d credit %0d with empty queue", o,
                                     f.payload[$bits(credit_t)-1:0]));
            end
        end else if (link_out[o].valid) begin
            check_count++;
            if (f.kind == CREDIT) begin
                report_err($sformatf("output %0d credit flit outside a slot", o));
            end else begin
                if (model_down[o] < credit_t'(CREDIT_THRESHOLD)) begin
                    report_err($sformatf("output %0d sent data with %0d credits", o,
                                         model_down[o]));
                end
                src = find_source(o, f);
                if (src < 0) begin
                    report_err($sformatf("output %0d unexpected flit %h", o, f));
                end else begin
                    if (src == PORT_NUM) begin
                        void'(inj_q[o].pop_front());
                    end else begin
                        void'(path_q[src*PORT_NUM+o].pop_front());
                        pending[src]--;
                    end
                    outstanding--;
                    owner[o] = (f.kind == TAIL) ? -1 : src;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        logic slot;
        flit_t f;
        if (rst) begin
            slot_cnt = 0;
            outstanding = 0;
            check_count = 0;
            error_count = 0;
            reported = 1'b0;
            for (int p = 0; p < PORT_NUM; p++) begin
                pending[p] = 0;
                owner[p] = -1;
                in_route[p] = PORT_NUM;
                in_pkt[p] = 1'b0;
                model_down[p] = credit_t'(QUEUE_DEPTH - 1);
            end
        end else begin
            slot = (slot_cnt == CREDIT_PERIOD - 1);
            slot_cnt = slot ? 0 : slot_cnt + 1;
            // injected flits leave in the same cycle, so record them first
            for (int p = 0; p < PORT_NUM; p++) begin
                if (inject[p].valid && inject_avail[p]) begin
                    inj_q[p].push_back(inject[p].flit);
                    outstanding++;
                end
                if (inject_avail[p] && (slot || model_down[p] < credit_t'(CREDIT_THRESHOLD))) begin
                    report_err($sformatf("inject_avail high on blocked output %0d", p));
                end
            end
            for (int o = 0; o < PORT_NUM; o++) begin
                check_output(o, slot);
            end
            for (int p = 0; p < PORT_NUM; p++) begin
                if (eject[p].valid) begin
                    check_count++;
                    if (eject_q[p].size() == 0 || eject_q[p][0] != eject[p].flit) begin
                        report_err($sformatf("eject %0d unexpected flit %h", p, eject[p].flit));
                    end else begin
                        void'(eject_q[p].pop_front());
                        pending[p]--;
                        outstanding--;
                    end
                end
            end
            for (int p = 0; p < PORT_NUM; p++) begin
                f = link_in[p].flit;
                if (link_in[p].valid && f.kind == CREDIT) begin
                    model_down[p] = f.payload[$bits(credit_t)-1:0];
                end else if (link_in[p].valid) begin
                    if (f.kind == HEAD || (f.kind == TAIL && !in_pkt[p])) begin
                        in_route[p] = dimension_order_exit(f.payload);
                    end
                    in_pkt[p] = (f.kind != TAIL);
                    if (in_route[p] == PORT_NUM) begin
                        eject_q[p].push_back(f);
                    end else begin
                        path_q[p*PORT_NUM+in_route[p]].push_back(f);
                    end
                    pending[p]++;
                    outstanding++;
                end
            end
            if (done && !reported) begin
                for (int q = 0; q < PORT_NUM*PORT_NUM; q++) begin
                    if (path_q[q].size() != 0) begin
                        error_count += path_q[q].size();
                        $display("%0d flits from input %0d never left output %0d",
                                 path_q[q].size(), q / PORT_NUM, q % PORT_NUM);
                    end
                end
                for (int p = 0; p < PORT_NUM; p++) begin
                    if (inj_q[p].size() + eject_q[p].size() != 0) begin
                        error_count += inj_q[p].size() + eject_q[p].size();
                        $display("port %0d still owes injected or ejected flits", p);
                    end
                end
                $display("checker: %0d checks, %0d errors", check_count, error_count);
                reported = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_router
    import router_pkg::*;
();

    localparam logic [31:0] SEED = 32'heb17_1b4c;
    localparam int NUM_PACKETS = 150;
    localparam int CUR = 2;
    localparam int CYCLE_LIMIT = 40 * NUM_PACKETS;

    logic clk;
    logic rst;
    link_t [PORT_NUM-1:0] link_in;
    link_t [PORT_NUM-1:0] link_out;
    link_t [PORT_NUM-1:0] inject;
    link_t [PORT_NUM-1:0] eject;
    logic [PORT_NUM-1:0] inject_avail;
    logic done;
    int error_count;
    logic reported;

    logic [31:0] rng;
    int started;
    logic traffic_on;
    int cycles;
    int link_len [PORT_NUM];
    int link_idx [PORT_NUM];
    int link_gap [PORT_NUM];
    logic [3*COORD_W-1:0] link_dest [PORT_NUM];
    logic credit_req [PORT_NUM];
    credit_t credit_val [PORT_NUM];
    int inj_len [PORT_NUM];
    int inj_idx [PORT_NUM];

    router #(
        .cur_x(CUR),
        .cur_y(CUR),
        .cur_z(CUR)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .link_in(link_in),
        .link_out(link_out),
        .inject(inject),
        .eject(eject),
        .inject_avail(inject_avail)
    );

    router_checker #(
        .cur_x(CUR),
        .cur_y(CUR),
        .cur_z(CUR)
    ) u_check (
        .clk(clk),
        .rst(rst),
        .link_in(link_in),
        .link_out(link_out),
        .inject(inject),
        .eject(eject),
        .inject_avail(inject_avail),
        .done(done),
        .error_count(error_count),
        .reported(reported)
    );

    bind router router_assertions u_assertions (
        .clk(clk),
        .rst(rst),
        .inject_avail(inject_avail),
        .link_out(link_out),
        .credit_slot(credit_slot),
        .down_credits(down_credits)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(input int n, output int v);
        rng = xorshift(rng);
        v = int'(rng % 32'(n));
    endtask

    function automatic flit_t make_flit(input int idx, input int len,
                                        input logic [3*COORD_W-1:0] dest,
                                        input logic [31:0] bits);
        flit_t f;
        f.payload = bits[PAYLOAD_W-1:0];
        if (idx == len - 1) begin
            f.kind = TAIL;
        end else if (idx == 0) begin
            f.kind = HEAD;
        end else begin
            f.kind = BODY;
        end
        // lone tail also carries the destination
        if (idx == 0) begin
            f.payload[PAYLOAD_W-1 -: 3*COORD_W] = dest;
        end
        return f;
    endfunction

    function automatic logic [3*COORD_W-1:0] dest_toward(input int d);
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] z;
        x = COORD_W'(CUR);
        y = COORD_W'(CUR);
        z = COORD_W'(CUR);
        case (d)
            0: x = 3'd5;
            1: y = 3'd5;
            2: z = 3'd5;
            3: x = 3'd0;
            4: y = 3'd0;
            default: z = 3'd0;
        endcase
        return {x, y, z};
    endfunction

    function automatic logic busy();
        logic b;
        b = 1'b0;
        for (int p = 0; p < PORT_NUM; p++) begin
            b |= (link_idx[p] < link_len[p]) || (inj_idx[p] < inj_len[p]);
            b |= credit_req[p] || (link_gap[p] != 0);
        end
        return b;
    endfunction

    // mid high phase, clear of both the checker and the driver
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic drain();
        while (busy() || u_check.outstanding != 0) begin
            step();
        end
    endtask

    task automatic check_gating(input int d);
        int s;
        s = (d + 1) % PORT_NUM;
        credit_val[d] = credit_t'(CREDIT_THRESHOLD - 7);
        credit_req[d] = 1'b1;
        link_len[s] = 3;
        link_idx[s] = 0;
        link_dest[s] = dest_toward(d);
        inj_len[d] = 2;
        inj_idx[d] = 0;
        repeat (60) step();
        credit_val[d] = credit_t'(QUEUE_DEPTH - 1);
        credit_req[d] = 1'b1;
        drain();
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // stimulus changes only on the falling edge
    always @(negedge clk) begin
        int r;
        logic [31:0] w;
        for (int p = 0; p < PORT_NUM; p++) begin
            link_in[p] = '0;
            if (link_gap[p] > 0) begin
                link_gap[p]--;
            end else if (credit_req[p]) begin
                link_in[p] = '{valid: 1'b1,
                               flit: '{kind: CREDIT, payload: PAYLOAD_W'(credit_val[p])}};
                credit_req[p] = 1'b0;
                link_gap[p] = 3;
            end else if (link_idx[p] < link_len[p]) begin
                next_rand(1 << 30, r);
                w = rng;
                link_in[p] = '{valid: 1'b1,
                               flit: make_flit(link_idx[p], link_len[p], link_dest[p], w)};
                link_idx[p]++;
                link_gap[p] = 3;
            end else if (traffic_on && started < NUM_PACKETS && u_check.pending[p] < 9) begin
                next_rand(8, r);
                if (r == 0) begin
                    next_rand(4, r);
                    link_len[p] = r + 1;
                    link_idx[p] = 0;
                    next_rand(4, r);
                    if (r == 0) begin
                        link_dest[p] = dest_toward(-1);
                        link_dest[p][COORD_W-1:0] = COORD_W'(CUR);
                    end else begin
                        next_rand(512, r);
                        link_dest[p] = r[8:0];
                    end
                    started++;
                end
            end

            inject[p] = '0;
            if (inj_idx[p] >= inj_len[p] && traffic_on && started < NUM_PACKETS) begin
                next_rand(40, r);
                if (r == 0) begin
                    next_rand(4, r);
                    inj_len[p] = r + 1;
                    inj_idx[p] = 0;
                    started++;
                end
            end
            if (inj_idx[p] < inj_len[p] && inject_avail[p]) begin
                next_rand(1 << 30, r);
                w = rng;
                inject[p] = '{valid: 1'b1,
                              flit: make_flit(inj_idx[p], inj_len[p], w[8:0], xorshift(w))};
                inj_idx[p]++;
            end
        end
    end

    initial begin
        rst = 1'b1;
        done = 1'b0;
        traffic_on = 1'b0;
        link_in = '0;
        inject = '0;
        rng = SEED;
        started = 0;
        cycles = 0;
        for (int p = 0; p < PORT_NUM; p++) begin
            link_len[p] = 0;
            link_idx[p] = 0;
            link_gap[p] = 0;
            link_dest[p] = '0;
            credit_req[p] = 1'b0;
            credit_val[p] = '0;
            inj_len[p] = 0;
            inj_idx[p] = 0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        step();

        traffic_on = 1'b1;
        while (started < NUM_PACKETS) begin
            step();
        end
        traffic_on = 1'b0;
        drain();

        // low credits on one link, then recovery
        check_gating(XPOS);
        check_gating(ZNEG);

        done = 1'b1;
        while (!reported) begin
            step();
        end
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
